// ==== Bender.yml ====
package:
  name: core_ctrl

sources:
  - rtl/ctrl_pkg.sv
  - rtl/hazard_if.sv
  - rtl/ctrl_fsm.sv
  - rtl/hazard_stall.sv
  - rtl/operand_fwd.sv
  - rtl/core_ctrl.sv
  - target: test
    files:
      - bench/core_ctrl_tb.sv

// ==== bench/core_ctrl_tb.sv ====
`timescale 1ns/1ns

module core_ctrl_tb;
  import ctrl_pkg::*;

  // 64 + 64 sweep cycles plus a few dozen directed ones, with wide margin
  localparam int CYCLE_LIMIT = 2000;

  logic clk;
  logic rst_n;
  logic fetch_enable, illegal_insn, eret_insn, pipe_flush, instr_valid;
  logic data_req_ex, data_load_event, branch_taken_ex;
  logic exc_req, ext_req, dbg_req, dbg_stall, dbg_jump_req;
  logic regfile_we_ex, regfile_we_wb, regfile_alu_we_fw;
  logic wb_a, wb_b, alu_a, alu_b, id_ready, ex_valid;
  branch_e jump_in_id, jump_in_dec;

  logic ctrl_busy, is_decoding, deassert_we, instr_req, pc_set;
  logic exc_ack, exc_save_if, exc_save_id, exc_save_tb, exc_restore_id;
  logic dbg_ack, halt_if, halt_id, jr_stall, load_stall;
  pc_mux_e pc_mux;
  fw_sel_e fw_a_sel, fw_b_sel;

  integer seed = 53;
  integer cycles = 0;

  core_ctrl i_core_ctrl (
    .clk(clk), .rst_n(rst_n), .fetch_enable_i(fetch_enable),
    .ctrl_busy_o(ctrl_busy), .is_decoding_o(is_decoding), .deassert_we_o(deassert_we),
    .illegal_insn_i(illegal_insn), .eret_insn_i(eret_insn), .pipe_flush_i(pipe_flush),
    .instr_valid_i(instr_valid), .instr_req_o(instr_req), .pc_set_o(pc_set),
    .pc_mux_o(pc_mux), .data_req_ex_i(data_req_ex), .data_load_event_i(data_load_event),
    .branch_taken_ex_i(branch_taken_ex), .jump_in_id_i(jump_in_id),
    .jump_in_dec_i(jump_in_dec), .exc_req_i(exc_req), .ext_req_i(ext_req),
    .exc_ack_o(exc_ack), .exc_save_if_o(exc_save_if), .exc_save_id_o(exc_save_id),
    .exc_save_takenbranch_o(exc_save_tb), .exc_restore_id_o(exc_restore_id),
    .dbg_req_i(dbg_req), .dbg_ack_o(dbg_ack), .dbg_stall_i(dbg_stall),
    .dbg_jump_req_i(dbg_jump_req), .regfile_we_ex_i(regfile_we_ex),
    .regfile_we_wb_i(regfile_we_wb), .regfile_alu_we_fw_i(regfile_alu_we_fw),
    .operand_a_fw_mux_sel_o(fw_a_sel), .operand_b_fw_mux_sel_o(fw_b_sel),
    .reg_d_wb_is_reg_a_i(wb_a), .reg_d_wb_is_reg_b_i(wb_b),
    .reg_d_alu_is_reg_a_i(alu_a), .reg_d_alu_is_reg_b_i(alu_b),
    .halt_if_o(halt_if), .halt_id_o(halt_id), .jr_stall_o(jr_stall),
    .load_stall_o(load_stall), .id_ready_i(id_ready), .ex_valid_i(ex_valid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // hang guard
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout, the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $fatal(1, "simulation stopped by cycle limit");
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERR %s actual=%h expected=%h", name, actual, expected);
      $display("Test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // inputs change 2 ns after the rising edge, checks happen at the falling edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic clear_flags();
    data_req_ex       = 1'b0;
    regfile_we_ex     = 1'b0;
    regfile_we_wb     = 1'b0;
    regfile_alu_we_fw = 1'b0;
    wb_a              = 1'b0;
    wb_b              = 1'b0;
    alu_a             = 1'b0;
    alu_b             = 1'b0;
  endtask

  ////////////////////
  // directed tests
  ////////////////////

  task automatic reset_and_boot();
    @(negedge clk);
    check_value("instr_req_o", instr_req, 0);
    check_value("ctrl_busy_o", ctrl_busy, 0);
    check_value("pc_set_o", pc_set, 0);
    check_value("dbg_ack_o", dbg_ack, 0);
    check_value("deassert_we_o", deassert_we, 1);
    check_value("pc_mux_o", pc_mux, PC_BOOT);
    next_cycle();
    fetch_enable = 1'b1;
    @(negedge clk);
    check_value("pc_set_o", pc_set, 0);
    // boot address load, one cycle only
    next_cycle();
    @(negedge clk);
    check_value("pc_set_o", pc_set, 1);
    check_value("pc_mux_o", pc_mux, PC_BOOT);
    next_cycle();
    instr_valid = 1'b1;
    @(negedge clk);
    check_value("pc_set_o", pc_set, 0);
    // first fetch done, now decoding
    next_cycle();
    @(negedge clk);
    check_value("is_decoding_o", is_decoding, 1);
    check_value("deassert_we_o", deassert_we, 0);
  endtask

  task automatic forwarding_sweep();
    logic [31:0] rnd;
    logic [1:0]  exp_a;
    logic [1:0]  exp_b;
    for (int i = 0; i < 64; i++) begin
      next_cycle();
      rnd = $random(seed);
      {regfile_we_wb, regfile_alu_we_fw, wb_a, wb_b, alu_a, alu_b} = rnd[5:0];
      @(negedge clk);
      // ex is newer than wb, register file otherwise
      exp_a = (regfile_alu_we_fw && alu_a) ? SEL_FW_EX :
              (regfile_we_wb && wb_a) ? SEL_FW_WB : SEL_REGFILE;
      exp_b = (regfile_alu_we_fw && alu_b) ? SEL_FW_EX :
              (regfile_we_wb && wb_b) ? SEL_FW_WB : SEL_REGFILE;
      check_value("operand_a_fw_mux_sel_o", fw_a_sel, exp_a);
      check_value("operand_b_fw_mux_sel_o", fw_b_sel, exp_b);
    end
    next_cycle();
    clear_flags();
  endtask

  task automatic stall_sweep();
    logic [31:0] rnd;
    logic        exp_load;
    logic        exp_jr;
    // id not ready keeps the fsm parked in decode while jumps sit in id
    id_ready = 1'b0;
    for (int i = 0; i < 64; i++) begin
      next_cycle();
      rnd = $random(seed);
      {data_req_ex, regfile_we_ex, regfile_we_wb, regfile_alu_we_fw} = rnd[3:0];
      {wb_a, wb_b, alu_a, alu_b} = rnd[7:4];
      illegal_insn = rnd[8];
      instr_valid  = rnd[9];
      jump_in_dec  = branch_e'(i % 4);
      @(negedge clk);
      exp_load = data_req_ex && regfile_we_ex && (alu_a || alu_b);
      exp_jr   = (jump_in_dec == BRANCH_JALR) &&
                 ((regfile_we_wb && wb_a) || ((regfile_we_ex || regfile_alu_we_fw) && alu_a));
      check_value("load_stall_o", load_stall, exp_load);
      check_value("jr_stall_o", jr_stall, exp_jr);
      check_value("deassert_we_o", deassert_we,
                  !instr_valid || illegal_insn || exp_load || exp_jr);
    end
    next_cycle();
    clear_flags();
    illegal_insn = 1'b0;
    instr_valid  = 1'b1;
    jump_in_dec  = BRANCH_NONE;
    id_ready     = 1'b1;
  endtask

  task automatic branch_and_jump();
    next_cycle();
    branch_taken_ex = 1'b1;
    @(negedge clk);
    check_value("pc_set_o", pc_set, 1);
    check_value("pc_mux_o", pc_mux, PC_BRANCH);
    check_value("is_decoding_o", is_decoding, 0);
    next_cycle();
    branch_taken_ex = 1'b0;
    jump_in_dec     = BRANCH_JAL;
    @(negedge clk);
    check_value("halt_if_o", halt_if, 1);
    check_value("pc_set_o", pc_set, 0);
    // target applied from WAIT_JUMP_EX
    next_cycle();
    jump_in_dec = BRANCH_NONE;
    @(negedge clk);
    check_value("pc_set_o", pc_set, 1);
    check_value("pc_mux_o", pc_mux, PC_JUMP);
    next_cycle();
    @(negedge clk);
    check_value("pc_set_o", pc_set, 0);
  endtask

  task automatic exception_entry();
    next_cycle();
    exc_req = 1'b1;
    @(negedge clk);
    check_value("exc_ack_o", exc_ack, 1);
    check_value("pc_set_o", pc_set, 1);
    check_value("pc_mux_o", pc_mux, PC_EXCEPTION);
    check_value("halt_id_o", halt_id, 1);
    check_value("exc_save_id_o", exc_save_id, 1);
    next_cycle();
    exc_req     = 1'b0;
    instr_valid = 1'b0;
    ext_req     = 1'b1;
    @(negedge clk);
    check_value("exc_ack_o", exc_ack, 1);
    check_value("pc_mux_o", pc_mux, PC_EXCEPTION);
    check_value("exc_save_if_o", exc_save_if, 1);
    check_value("exc_save_id_o", exc_save_id, 0);
    // interrupt on top of a taken branch
    next_cycle();
    instr_valid     = 1'b1;
    branch_taken_ex = 1'b1;
    @(negedge clk);
    check_value("exc_save_takenbranch_o", exc_save_tb, 1);
    check_value("pc_mux_o", pc_mux, PC_EXCEPTION);
    next_cycle();
    ext_req         = 1'b0;
    branch_taken_ex = 1'b0;
    eret_insn       = 1'b1;
    @(negedge clk);
    check_value("pc_mux_o", pc_mux, PC_ERET);
    check_value("exc_restore_id_o", exc_restore_id, 1);
    check_value("pc_set_o", pc_set, 1);
    next_cycle();
    eret_insn = 1'b0;
    @(negedge clk);
    check_value("exc_restore_id_o", exc_restore_id, 0);
  endtask

  task automatic debug_and_sleep();
    next_cycle();
    dbg_req   = 1'b1;
    dbg_stall = 1'b1;
    @(negedge clk);
    check_value("dbg_ack_o", dbg_ack, 0);
    next_cycle();
    dbg_req = 1'b0;
    @(negedge clk);
    check_value("dbg_ack_o", dbg_ack, 1);
    check_value("halt_if_o", halt_if, 1);
    // debugger holds the core
    next_cycle();
    @(negedge clk);
    check_value("dbg_ack_o", dbg_ack, 0);
    check_value("halt_if_o", halt_if, 1);
    next_cycle();
    dbg_stall = 1'b0;
    @(negedge clk);
    check_value("halt_if_o", halt_if, 1);
    next_cycle();
    @(negedge clk);
    check_value("halt_if_o", halt_if, 0);
    check_value("dbg_ack_o", dbg_ack, 0);

    ////////////////////
    // flush into sleep
    next_cycle();
    fetch_enable = 1'b0;
    pipe_flush   = 1'b1;
    @(negedge clk);
    check_value("halt_id_o", halt_id, 1);
    next_cycle();
    pipe_flush = 1'b0;
    ex_valid   = 1'b1;
    @(negedge clk);
    check_value("ctrl_busy_o", ctrl_busy, 1);
    next_cycle();
    ex_valid = 1'b0;
    @(negedge clk);
    check_value("ctrl_busy_o", ctrl_busy, 1);
    next_cycle();
    @(negedge clk);
    check_value("ctrl_busy_o", ctrl_busy, 0);
    check_value("halt_if_o", halt_if, 1);
    check_value("halt_id_o", halt_id, 1);
    // interrupt wakes the core
    next_cycle();
    exc_req = 1'b1;
    @(negedge clk);
    check_value("ctrl_busy_o", ctrl_busy, 0);
    next_cycle();
    exc_req = 1'b0;
    @(negedge clk);
    check_value("ctrl_busy_o", ctrl_busy, 1);
  endtask

  initial begin
    rst_n           = 1'b0;
    fetch_enable    = 1'b0;
    illegal_insn    = 1'b0;
    eret_insn       = 1'b0;
    pipe_flush      = 1'b0;
    instr_valid     = 1'b0;
    data_load_event = 1'b0;
    branch_taken_ex = 1'b0;
    exc_req         = 1'b0;
    ext_req         = 1'b0;
    dbg_req         = 1'b0;
    dbg_stall       = 1'b0;
    dbg_jump_req    = 1'b0;
    id_ready        = 1'b1;
    ex_valid        = 1'b0;
    jump_in_id      = BRANCH_NONE;
    jump_in_dec     = BRANCH_NONE;
    clear_flags();
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;

    reset_and_boot();
    forwarding_sweep();
    stall_sweep();
    branch_and_jump();
    exception_entry();
    debug_and_sleep();

    $display("Test passed");
    $finish;
  end

endmodule

// ==== core_ctrl.f ====
rtl/ctrl_pkg.sv
rtl/hazard_if.sv
rtl/ctrl_fsm.sv
rtl/hazard_stall.sv
rtl/operand_fwd.sv
rtl/core_ctrl.sv
bench/core_ctrl_tb.sv

// ==== rtl/core_ctrl.sv ====
`timescale 1ns/1ns

module core_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               fetch_enable_i,
  output logic               ctrl_busy_o,
  output logic               is_decoding_o,
  // decoder
  output logic               deassert_we_o,
  input  logic               illegal_insn_i,
  input  logic               eret_insn_i,
  input  logic               pipe_flush_i,
  input  logic               instr_valid_i,
  // fetch
  output logic               instr_req_o,
  output logic               pc_set_o,
  output ctrl_pkg::pc_mux_e  pc_mux_o,
  // lsu
  input  logic               data_req_ex_i,
  input  logic               data_load_event_i,
  // control flow
  input  logic               branch_taken_ex_i,
  input  ctrl_pkg::branch_e  jump_in_id_i,
  input  ctrl_pkg::branch_e  jump_in_dec_i,
  // exceptions
  input  logic               exc_req_i,
  input  logic               ext_req_i,
  output logic               exc_ack_o,
  output logic               exc_save_if_o,
  output logic               exc_save_id_o,
  output logic               exc_save_takenbranch_o,
  output logic               exc_restore_id_o,
  // debug
  input  logic               dbg_req_i,
  output logic               dbg_ack_o,
  input  logic               dbg_stall_i,
  input  logic               dbg_jump_req_i,
  // forwarding
  input  logic               regfile_we_ex_i,
  input  logic               regfile_we_wb_i,
  input  logic               regfile_alu_we_fw_i,
  output ctrl_pkg::fw_sel_e  operand_a_fw_mux_sel_o,
  output ctrl_pkg::fw_sel_e  operand_b_fw_mux_sel_o,
  input  logic               reg_d_wb_is_reg_a_i,
  input  logic               reg_d_wb_is_reg_b_i,
  input  logic               reg_d_alu_is_reg_a_i,
  input  logic               reg_d_alu_is_reg_b_i,
  // stalls
  output logic               halt_if_o,
  output logic               halt_id_o,
  output logic               jr_stall_o,
  output logic               load_stall_o,
  input  logic               id_ready_i,
  input  logic               ex_valid_i
);
  import ctrl_pkg::*;

  hazard_if hz_bus ();

  // pipeline flags into the hazard bundle
  assign hz_bus.data_req_ex       = data_req_ex_i;
  assign hz_bus.regfile_we_ex     = regfile_we_ex_i;
  assign hz_bus.regfile_we_wb     = regfile_we_wb_i;
  assign hz_bus.regfile_alu_we_fw = regfile_alu_we_fw_i;
  assign hz_bus.wb_is_a           = reg_d_wb_is_reg_a_i;
  assign hz_bus.wb_is_b           = reg_d_wb_is_reg_b_i;
  assign hz_bus.alu_is_a          = reg_d_alu_is_reg_a_i;
  assign hz_bus.alu_is_b          = reg_d_alu_is_reg_b_i;

  ctrl_fsm i_ctrl_fsm (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .fetch_enable_i         (fetch_enable_i),
    .eret_insn_i            (eret_insn_i),
    .pipe_flush_i           (pipe_flush_i),
    .instr_valid_i          (instr_valid_i),
    .id_ready_i             (id_ready_i),
    .ex_valid_i             (ex_valid_i),
    .branch_taken_ex_i      (branch_taken_ex_i),
    .jump_in_id_i           (jump_in_id_i),
    .jump_in_dec_i          (jump_in_dec_i),
    .exc_req_i              (exc_req_i),
    .ext_req_i              (ext_req_i),
    .dbg_req_i              (dbg_req_i),
    .dbg_stall_i            (dbg_stall_i),
    .dbg_jump_req_i         (dbg_jump_req_i),
    .data_load_event_i      (data_load_event_i),
    .jr_stall_i             (jr_stall_o),
    .instr_req_o            (instr_req_o),
    .ctrl_busy_o            (ctrl_busy_o),
    .is_decoding_o          (is_decoding_o),
    .pc_set_o               (pc_set_o),
    .pc_mux_o               (pc_mux_o),
    .exc_ack_o              (exc_ack_o),
    .exc_save_if_o          (exc_save_if_o),
    .exc_save_id_o          (exc_save_id_o),
    .exc_save_takenbranch_o (exc_save_takenbranch_o),
    .exc_restore_id_o       (exc_restore_id_o),
    .dbg_ack_o              (dbg_ack_o),
    .halt_if_o              (halt_if_o),
    .halt_id_o              (halt_id_o)
  );

  // stall detection runs off the fsm decode flag
  hazard_stall i_hazard_stall (
    .hz             (hz_bus.stall),
    .jump_in_dec_i  (jump_in_dec_i),
    .is_decoding_i  (is_decoding_o),
    .illegal_insn_i (illegal_insn_i),
    .load_stall_o   (load_stall_o),
    .jr_stall_o     (jr_stall_o),
    .deassert_we_o  (deassert_we_o)
  );

  operand_fwd i_operand_fwd (
    .hz                     (hz_bus.fwd),
    .operand_a_fw_mux_sel_o (operand_a_fw_mux_sel_o),
    .operand_b_fw_mux_sel_o (operand_b_fw_mux_sel_o)
  );

endmodule

// ==== rtl/ctrl_fsm.sv ====
`timescale 1ns/1ns

module ctrl_fsm (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               fetch_enable_i,
  input  logic               eret_insn_i,
  input  logic               pipe_flush_i,
  input  logic               instr_valid_i,
  input  logic               id_ready_i,
  input  logic               ex_valid_i,
  input  logic               branch_taken_ex_i,
  input  ctrl_pkg::branch_e  jump_in_id_i,
  input  ctrl_pkg::branch_e  jump_in_dec_i,
  input  logic               exc_req_i,
  input  logic               ext_req_i,
  input  logic               dbg_req_i,
  input  logic               dbg_stall_i,
  input  logic               dbg_jump_req_i,
  input  logic               data_load_event_i,
  input  logic               jr_stall_i,
  output logic               instr_req_o,
  output logic               ctrl_busy_o,
  output logic               is_decoding_o,
  output logic               pc_set_o,
  output ctrl_pkg::pc_mux_e  pc_mux_o,
  output logic               exc_ack_o,
  output logic               exc_save_if_o,
  output logic               exc_save_id_o,
  output logic               exc_save_takenbranch_o,
  output logic               exc_restore_id_o,
  output logic               dbg_ack_o,
  output logic               halt_if_o,
  output logic               halt_id_o
);
  import ctrl_pkg::*;

  ctrl_state_e state_q, state_d;
  logic        jump_done_q, jump_done_d;
  logic        is_jump;

  // unconditional jumps are resolved through WAIT_JUMP_EX
  assign is_jump = (jump_in_dec_i == BRANCH_JAL) || (jump_in_dec_i == BRANCH_JALR);

  ////////////////////
  // next state / outputs
  ////////////////////

  always_comb begin
    // defaults for a core that is running normally
    instr_req_o            = 1'b1;
    ctrl_busy_o            = 1'b1;
    is_decoding_o          = 1'b0;
    pc_set_o               = 1'b0;
    pc_mux_o               = PC_BOOT;
    exc_ack_o              = 1'b0;
    exc_save_if_o          = 1'b0;
    exc_save_id_o          = 1'b0;
    exc_save_takenbranch_o = 1'b0;
    exc_restore_id_o       = 1'b0;
    dbg_ack_o              = 1'b0;
    halt_if_o              = 1'b0;
    halt_id_o              = 1'b0;
    jump_done_d            = jump_done_q;
    state_d                = state_q;

    unique case (state_q)
      // idle until fetch is enabled
      RESET: begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end else if (dbg_req_i) begin
          // debugger may attach before boot, npc stays unset
          state_d = DBG_SIGNAL;
        end
      end

      // load boot address into fetch
      BOOT_SET: begin
        pc_mux_o = PC_BOOT;
        pc_set_o = 1'b1;
        state_d  = FIRST_FETCH;
      end

      SLEEP: begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        // wake on enable or pending interrupt
        if (dbg_req_i) begin
          state_d = (fetch_enable_i || exc_req_i) ? DBG_SIGNAL : DBG_SIGNAL_SLEEP;
        end else if (fetch_enable_i || exc_req_i) begin
          state_d = FIRST_FETCH;
        end
      end

      // wait for the first instruction to reach id
      FIRST_FETCH: begin
        if (id_ready_i && !dbg_stall_i) begin
          state_d = DECODE;
        end
        // interrupt on wakeup, nothing in id yet
        if (exc_req_i) begin
          pc_mux_o      = PC_EXCEPTION;
          pc_set_o      = 1'b1;
          exc_ack_o     = 1'b1;
          exc_save_if_o = 1'b1;
        end
      end

      DECODE: begin
        if (instr_valid_i && !branch_taken_ex_i) begin
          is_decoding_o = 1'b1;
          if (is_jump) begin
            // hold fetch, target comes from ex next cycle
            halt_if_o = 1'b1;
            if (id_ready_i && !jr_stall_i && !jump_done_q) begin
              state_d = WAIT_JUMP_EX;
            end
          end else if (exc_req_i) begin
            // keep the trapping instruction out of ex
            pc_mux_o      = PC_EXCEPTION;
            pc_set_o      = 1'b1;
            exc_ack_o     = 1'b1;
            halt_id_o     = 1'b1;
            exc_save_id_o = 1'b1;
          end

          // return from exception, applied once per instruction
          if (eret_insn_i) begin
            pc_mux_o         = PC_ERET;
            exc_restore_id_o = 1'b1;
            if (!jump_done_q) begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end

          // wfi, or eret back into sleep
          if (pipe_flush_i || (eret_insn_i && !fetch_enable_i)) begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end else if (dbg_req_i) begin
            halt_if_o = 1'b1;
            // let the id instruction leave first
            if (id_ready_i) begin
              state_d = (jump_in_id_i == BRANCH_COND) ? DBG_WAIT_BRANCH : DBG_SIGNAL;
            end else if (data_load_event_i) begin
              // event load sits in ex, enter debug anyway
              state_d = DBG_SIGNAL;
            end
          end
        end else if (!instr_valid_i && !branch_taken_ex_i && ext_req_i) begin
          // interrupt with an empty id stage
          pc_mux_o      = PC_EXCEPTION;
          pc_set_o      = 1'b1;
          exc_ack_o     = 1'b1;
          halt_id_o     = 1'b1;
          exc_save_if_o = 1'b1;
        end

        // taken branch from ex, id holds a wrong-path instruction
        if (branch_taken_ex_i) begin
          pc_mux_o = PC_BRANCH;
          pc_set_o = 1'b1;
          if (ext_req_i) begin
            pc_mux_o               = PC_EXCEPTION;
            exc_ack_o              = 1'b1;
            halt_id_o              = 1'b1;
            exc_save_takenbranch_o = 1'b1;
          end
          if (dbg_req_i) begin
            state_d = DBG_SIGNAL;
          end
        end
      end

      // jump target now valid in ex
      WAIT_JUMP_EX: begin
        pc_mux_o    = PC_JUMP;
        pc_set_o    = 1'b1;
        jump_done_d = 1'b1;
        state_d     = DECODE;
      end

      // drain ex, then wb
      FLUSH_EX: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i) begin
          state_d = FLUSH_WB;
        end
      end

      FLUSH_WB: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (fetch_enable_i) begin
          if (dbg_req_i) begin
            state_d = DBG_SIGNAL;
          end else begin
            halt_if_o = 1'b0;
            state_d   = DECODE;
          end
        end else begin
          state_d = dbg_req_i ? DBG_SIGNAL_SLEEP : SLEEP;
        end
      end

      // branch in ex resolves before debug entry
      DBG_WAIT_BRANCH: begin
        halt_if_o = 1'b1;
        if (branch_taken_ex_i) begin
          pc_mux_o = PC_BRANCH;
          pc_set_o = 1'b1;
        end
        state_d = DBG_SIGNAL;
      end

      ////////////////////
      // debug handshake
      ////////////////////

      DBG_SIGNAL: begin
        dbg_ack_o = 1'b1;
        halt_if_o = 1'b1;
        state_d   = DBG_WAIT;
      end

      DBG_SIGNAL_SLEEP: begin
        dbg_ack_o = 1'b1;
        halt_if_o = 1'b1;
        state_d   = DBG_WAIT_SLEEP;
      end

      // debugger owns the core, npc may be rewritten
      DBG_WAIT: begin
        halt_if_o = 1'b1;
        if (dbg_jump_req_i) begin
          pc_mux_o = PC_DBG_NPC;
          pc_set_o = 1'b1;
        end
        if (!dbg_stall_i) begin
          state_d = DECODE;
        end
      end

      DBG_WAIT_SLEEP: begin
        halt_if_o = 1'b1;
        if (dbg_jump_req_i) begin
          pc_mux_o = PC_DBG_NPC;
          pc_set_o = 1'b1;
          state_d  = DBG_WAIT;
        end
        if (!dbg_stall_i) begin
          state_d = SLEEP;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      // cleared once id accepts the next instruction
      jump_done_q <= jump_done_d & ~id_ready_i;
    end
  end

  // no branch prediction in fetch, so taken branches cannot be adjacent
  a_no_b2b_branch : assert property (@(posedge clk) disable iff (!rst_n)
    branch_taken_ex_i |=> !branch_taken_ex_i)
    else $error("two taken branches back to back");

  a_dbg_ext_excl : assert property (@(posedge clk) disable iff (!rst_n)
    !(dbg_req_i && ext_req_i))
    else $error("debug and interrupt request at once");

endmodule

// ==== rtl/ctrl_pkg.sv ====
package ctrl_pkg;

  ////////////////////
  // fetch pc source
  ////////////////////

  // gaps in the encoding are left for sources handled elsewhere in the core
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd2,
    PC_BRANCH    = 3'd3,
    PC_EXCEPTION = 3'd4,
    PC_ERET      = 3'd5,
    PC_DBG_NPC   = 3'd7
  } pc_mux_e;

  // control-flow kind as reported by the decoder
  typedef enum logic [1:0] {
    BRANCH_NONE = 2'd0,
    BRANCH_JAL  = 2'd1,
    BRANCH_JALR = 2'd2,
    BRANCH_COND = 2'd3
  } branch_e;

  // operand source in the id stage
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'd0,
    SEL_FW_EX   = 2'd1,
    SEL_FW_WB   = 2'd2
  } fw_sel_e;

  ////////////////////
  // controller fsm
  ////////////////////

  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    WAIT_JUMP_EX,
    FLUSH_EX,
    FLUSH_WB,
    DBG_SIGNAL,
    DBG_SIGNAL_SLEEP,
    DBG_WAIT,
    DBG_WAIT_BRANCH,
    DBG_WAIT_SLEEP
  } ctrl_state_e;

endpackage

// ==== rtl/hazard_if.sv ====
`timescale 1ns/1ns

interface hazard_if;

  // lsu access and write enables of the later stages
  logic data_req_ex;
  logic regfile_we_ex;
  logic regfile_we_wb;
  logic regfile_alu_we_fw;

  // destination of wb / ex matches source a or b in id
  logic wb_is_a;
  logic wb_is_b;
  logic alu_is_a;
  logic alu_is_b;

  modport src (
    output data_req_ex, regfile_we_ex, regfile_we_wb, regfile_alu_we_fw,
    output wb_is_a, wb_is_b, alu_is_a, alu_is_b
  );

  modport stall (
    input data_req_ex, regfile_we_ex, regfile_we_wb, regfile_alu_we_fw,
    input wb_is_a, alu_is_a, alu_is_b
  );

  modport fwd (
    input regfile_we_wb, regfile_alu_we_fw,
    input wb_is_a, wb_is_b, alu_is_a, alu_is_b
  );

endinterface

// ==== rtl/hazard_stall.sv ====
`timescale 1ns/1ns

module hazard_stall (
  hazard_if.stall           hz,
  input  ctrl_pkg::branch_e jump_in_dec_i,
  input  logic              is_decoding_i,
  input  logic              illegal_insn_i,
  output logic              load_stall_o,
  output logic              jr_stall_o,
  output logic              deassert_we_o
);
  import ctrl_pkg::*;

  logic ex_pending_a;
  logic wb_pending_a;

  // a write to operand a is still in flight
  assign ex_pending_a = (hz.regfile_we_ex || hz.regfile_alu_we_fw) && hz.alu_is_a;
  assign wb_pending_a = hz.regfile_we_wb && hz.wb_is_a;

  always_comb begin
    // load in ex feeding an operand of the id instruction
    load_stall_o = hz.data_req_ex && hz.regfile_we_ex && (hz.alu_is_a || hz.alu_is_b);

    // jalr target register not yet written back
    jr_stall_o = (jump_in_dec_i == BRANCH_JALR) && (ex_pending_a || wb_pending_a);

    // no writeback for a stalled, illegal or undecoded instruction
    deassert_we_o = !is_decoding_i || illegal_insn_i || load_stall_o || jr_stall_o;
  end

endmodule

// ==== rtl/operand_fwd.sv ====
`timescale 1ns/1ns

module operand_fwd (
  hazard_if.fwd             hz,
  output ctrl_pkg::fw_sel_e operand_a_fw_mux_sel_o,
  output ctrl_pkg::fw_sel_e operand_b_fw_mux_sel_o
);
  import ctrl_pkg::*;

  // per operand pick, ex result is newer than wb
  function automatic fw_sel_e fw_pick(input logic wb_hit, input logic ex_hit);
    fw_sel_e sel;
    sel = SEL_REGFILE;
    if (wb_hit) begin
      sel = SEL_FW_WB;
    end
    if (ex_hit) begin
      sel = SEL_FW_EX;
    end
    return sel;
  endfunction

  always_comb begin
    operand_a_fw_mux_sel_o = fw_pick(hz.regfile_we_wb && hz.wb_is_a,
                                     hz.regfile_alu_we_fw && hz.alu_is_a);
    operand_b_fw_mux_sel_o = fw_pick(hz.regfile_we_wb && hz.wb_is_b,
                                     hz.regfile_alu_we_fw && hz.alu_is_b);
  end

endmodule
